/* fp_cvt_pkg.sv */
// integer to float conversion package
`default_nettype none

package fp_cvt_pkg;

    // datapath widths
    localparam int int_w  = 64;
    localparam int mant_w = 54;
    localparam int exp_w  = 14;
    localparam int lzc_w  = 6;

    typedef logic [1:0] op_t;
    typedef logic       fmt_t;
    typedef logic [2:0] rm_t;

    localparam logic [exp_w-1:0] bias_single = 14'd127;
    localparam logic [exp_w-1:0] bias_double = 14'd1023;

    // exponent of the operand msb per width
    localparam logic [lzc_w-1:0] top_bit_32 = 6'd31;
    localparam logic [lzc_w-1:0] top_bit_64 = 6'd63;

    // bit 1 selects the 64-bit operand
    localparam op_t op_i32 = 2'd0;
    localparam op_t op_u32 = 2'd1;
    localparam op_t op_i64 = 2'd2;
    localparam op_t op_u64 = 2'd3;

    localparam fmt_t fmt_single = 1'b0;
    localparam fmt_t fmt_double = 1'b1;

    // operand word, full 64-bit or 32-bit in the low half
    typedef union packed {
        logic signed [int_w-1:0] w64;
        struct packed {
            logic [31:0]        pad;
            logic signed [31:0] low;
        } w32;
    } int_operand_u;

endpackage

`default_nettype wire

/* i2f_stage_if.sv */
// conversion stage records
`timescale 1ns/1ps
`default_nettype none

// unpack to normalize
interface i2f_unpacked_if;
    logic                           valid;
    logic                           sign;
    logic [fp_cvt_pkg::int_w-1:0]   mag;
    logic [fp_cvt_pkg::lzc_w-1:0]   top_exp;
    fp_cvt_pkg::fmt_t               fmt;
    fp_cvt_pkg::rm_t                rm;

    modport src (output valid, sign, mag, top_exp, fmt, rm);
    modport dst (input valid, sign, mag, top_exp, fmt, rm);
endinterface

// normalize to result pack
interface i2f_norm_if;
    logic                           valid;
    logic                           sign;
    logic [fp_cvt_pkg::int_w-1:0]   norm;
    logic [fp_cvt_pkg::exp_w-1:0]   exponent;
    logic                           zero;
    fp_cvt_pkg::fmt_t               fmt;
    fp_cvt_pkg::rm_t                rm;

    modport src (output valid, sign, norm, exponent, zero, fmt, rm);
    modport dst (input valid, sign, norm, exponent, zero, fmt, rm);
endinterface

`default_nettype wire

/* i2f_operand_unpack.sv */
// integer operand unpack stage
`timescale 1ns/1ps
`default_nettype none

module i2f_operand_unpack (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         valid_i,
    input  wire fp_cvt_pkg::op_t              op_i,
    input  wire fp_cvt_pkg::fmt_t             fmt_i,
    input  wire fp_cvt_pkg::rm_t              rm_i,
    input  wire logic [fp_cvt_pkg::int_w-1:0] data_i,
    i2f_unpacked_if.src                       out
);

    fp_cvt_pkg::int_operand_u       opnd;
    logic                           wide;
    logic                           neg;
    logic [31:0]                    mag32;
    logic [fp_cvt_pkg::int_w-1:0]   mag64;
    logic [fp_cvt_pkg::int_w-1:0]   mag_c;
    logic [fp_cvt_pkg::lzc_w-1:0]   top_c;

    always_comb begin
        opnd = data_i;
        wide = 1'b1;
        neg  = 1'b0;
        case (op_i)
            fp_cvt_pkg::op_i32: begin
                wide = 1'b0;
                neg  = opnd.w32.low[31];
            end
            fp_cvt_pkg::op_u32: wide = 1'b0;
            fp_cvt_pkg::op_i64: neg = opnd.w64[63];
            fp_cvt_pkg::op_u64: neg = 1'b0;
        endcase

        // two's complement magnitude, msb of 32-bit min stays set
        mag32 = neg ? -opnd.w32.low : opnd.w32.low;
        mag64 = neg ? -opnd.w64 : opnd.w64;

        // 32-bit operands sit in the upper half
        mag_c = wide ? mag64 : {mag32, 32'h0};
        top_c = wide ? fp_cvt_pkg::top_bit_64 : fp_cvt_pkg::top_bit_32;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            out.sign    <= neg;
            out.mag     <= mag_c;
            out.top_exp <= top_c;
            out.fmt     <= fmt_i;
            out.rm      <= rm_i;
        end
    end

endmodule

`default_nettype wire

/* lzc_64.sv */
// 64-bit leading zero counter
`timescale 1ns/1ps
`default_nettype none

module lzc_64 (
    input  wire logic [63:0]                  data_i,
    output logic [fp_cvt_pkg::lzc_w-1:0]      count_o,
    output logic                              all_zero_o
);

    logic [15:0]      nib_nz;
    logic [15:0][1:0] nib_cnt;
    logic [3:0]       q_nz;
    logic [3:0][3:0]  q_cnt;
    logic [1:0]       h_nz;
    logic [1:0][4:0]  h_cnt;

    always_comb begin
        logic [3:0] nib;
        // level 1, per nibble
        for (int i = 0; i < 16; i++) begin
            nib        = data_i[4*i +: 4];
            nib_nz[i]  = |nib;
            nib_cnt[i] = {~nib[3] & ~nib[2], ~nib[3] & (nib[2] | ~nib[1])};
        end

        // level 2, 16-bit groups; highest nonzero nibble wins
        for (int g = 0; g < 4; g++) begin
            q_nz[g]  = |nib_nz[4*g +: 4];
            q_cnt[g] = {2'd3, nib_cnt[4*g]};
            for (int k = 0; k < 4; k++) begin
                if (nib_nz[4*g+k]) begin
                    q_cnt[g] = {2'(3 - k), nib_cnt[4*g+k]};
                end
            end
        end

        // level 3, 32-bit halves
        for (int j = 0; j < 2; j++) begin
            h_nz[j]  = q_nz[2*j+1] | q_nz[2*j];
            h_cnt[j] = q_nz[2*j+1] ? {1'b0, q_cnt[2*j+1]} : {1'b1, q_cnt[2*j]};
        end
    end

    // level 4
    assign count_o    = h_nz[1] ? {1'b0, h_cnt[1]} : {1'b1, h_cnt[0]};
    assign all_zero_o = ~|h_nz;

endmodule

`default_nettype wire

/* i2f_normalize.sv */
// leading zero normalize stage
`timescale 1ns/1ps
`default_nettype none

module i2f_normalize (
    input  wire logic   clk,
    input  wire logic   rst_n,
    i2f_unpacked_if.dst in,
    i2f_norm_if.src     out
);

    logic [fp_cvt_pkg::lzc_w-1:0]   lz;
    logic                           all_zero;
    logic [fp_cvt_pkg::exp_w-1:0]   bias;
    logic [fp_cvt_pkg::exp_w-1:0]   lz_ext;
    logic [fp_cvt_pkg::exp_w-1:0]   top_ext;
    logic [fp_cvt_pkg::exp_w-1:0]   exp_c;
    logic [fp_cvt_pkg::int_w-1:0]   norm_c;

    lzc_64 u_lzc (
        .data_i     (in.mag),
        .count_o    (lz),
        .all_zero_o (all_zero)
    );

    always_comb begin
        case (in.fmt)
            fp_cvt_pkg::fmt_single: bias = fp_cvt_pkg::bias_single;
            default:                bias = fp_cvt_pkg::bias_double;
        endcase

        lz_ext  = {{(fp_cvt_pkg::exp_w - fp_cvt_pkg::lzc_w){1'b0}}, lz};
        top_ext = {{(fp_cvt_pkg::exp_w - fp_cvt_pkg::lzc_w){1'b0}}, in.top_exp};

        // leading one lands on bit 63
        norm_c = in.mag << lz;
        exp_c  = top_ext + bias - lz_ext;

        if (all_zero) begin
            norm_c = '0;
            exp_c  = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.sign     <= in.sign;
            out.norm     <= norm_c;
            out.exponent <= exp_c;
            out.zero     <= all_zero;
            out.fmt      <= in.fmt;
            out.rm       <= in.rm;
        end
    end

endmodule

`default_nettype wire

/* i2f_result_pack.sv */
// result field extraction stage
`timescale 1ns/1ps
`default_nettype none

module i2f_result_pack (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    i2f_norm_if.dst                            in,
    output logic                               valid_o,
    output logic                               sign_o,
    output logic [fp_cvt_pkg::exp_w-1:0]       exponent_o,
    output logic [fp_cvt_pkg::mant_w-1:0]      mantissa_o,
    output logic [2:0]                         grs_o,
    output fp_cvt_pkg::fmt_t                   fmt_o,
    output fp_cvt_pkg::rm_t                    rm_o,
    output logic                               zero_o
);

    logic [fp_cvt_pkg::mant_w-1:0]  mant_c;
    logic [2:0]                     grs_c;

    always_comb begin
        if (in.fmt == fp_cvt_pkg::fmt_double) begin
            mant_c = {1'b0, in.norm[63:11]};
            grs_c  = {in.norm[10], in.norm[9], |in.norm[8:0]};
        end else begin
            // 24-bit single mantissa, zero extended
            mant_c = {30'h0, in.norm[63:40]};
            grs_c  = {in.norm[39], in.norm[38], |in.norm[37:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o    <= 1'b0;
            sign_o     <= 1'b0;
            exponent_o <= '0;
            mantissa_o <= '0;
            grs_o      <= '0;
            fmt_o      <= '0;
            rm_o       <= '0;
            zero_o     <= 1'b0;
        end else begin
            valid_o <= in.valid;
            // fields hold while idle
            if (in.valid) begin
                sign_o     <= in.sign;
                exponent_o <= in.exponent;
                mantissa_o <= mant_c;
                grs_o      <= grs_c;
                fmt_o      <= in.fmt;
                rm_o       <= in.rm;
                zero_o     <= in.zero;
            end
        end
    end

endmodule

`default_nettype wire

/* fp_i2f_cvt.sv */
// integer to float converter top
`timescale 1ns/1ps
`default_nettype none

module fp_i2f_cvt (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          valid_i,
    input  wire fp_cvt_pkg::op_t               op_i,
    input  wire fp_cvt_pkg::fmt_t              fmt_i,
    input  wire fp_cvt_pkg::rm_t               rm_i,
    input  wire logic [fp_cvt_pkg::int_w-1:0]  data_i,
    output logic                               valid_o,
    output logic                               sign_o,
    output logic [fp_cvt_pkg::exp_w-1:0]       exponent_o,
    output logic [fp_cvt_pkg::mant_w-1:0]      mantissa_o,
    output logic [2:0]                         grs_o,
    output fp_cvt_pkg::fmt_t                   fmt_o,
    output fp_cvt_pkg::rm_t                    rm_o,
    output logic                               zero_o
);

    i2f_unpacked_if unp_if ();
    i2f_norm_if     norm_if ();

    // stage 1
    i2f_operand_unpack u_unpack (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .op_i    (op_i),
        .fmt_i   (fmt_i),
        .rm_i    (rm_i),
        .data_i  (data_i),
        .out     (unp_if.src)
    );

    // stage 2
    i2f_normalize u_normalize (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (unp_if.dst),
        .out   (norm_if.src)
    );

    // stage 3
    i2f_result_pack u_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (norm_if.dst),
        .valid_o    (valid_o),
        .sign_o     (sign_o),
        .exponent_o (exponent_o),
        .mantissa_o (mantissa_o),
        .grs_o      (grs_o),
        .fmt_o      (fmt_o),
        .rm_o       (rm_o),
        .zero_o     (zero_o)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held over the first three rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* fp_i2f_cvt_sva.sv */
// converter result checker
`timescale 1ns/1ps
`default_nettype none

module fp_i2f_cvt_sva (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        valid_i,
    input wire logic [1:0]  op_i,
    input wire logic        fmt_i,
    input wire logic [2:0]  rm_i,
    input wire logic [63:0] data_i,
    input wire logic        valid_o,
    input wire logic        sign_o,
    input wire logic [13:0] exponent_o,
    input wire logic [53:0] mantissa_o,
    input wire logic [2:0]  grs_o,
    input wire logic        fmt_o,
    input wire logic [2:0]  rm_o,
    input wire logic        zero_o
);

    int unsigned fail_count = 0;

    // index 2 of the input history lines up with the outputs
    logic [2:0]       hv;
    logic [2:0][1:0]  hop;
    logic [2:0]       hfmt;
    logic [2:0][2:0]  hrm;
    logic [2:0][63:0] hdata;

    logic        e_sign;
    logic [13:0] e_exp;
    logic [53:0] e_mant;
    logic [2:0]  e_grs;
    logic        e_zero;

    function automatic void model(
        input  logic [1:0]  op,
        input  logic        fmt,
        input  logic [63:0] data,
        output logic        sign,
        output logic [13:0] expo,
        output logic [53:0] mant,
        output logic [2:0]  grs,
        output logic        zero
    );
        logic [63:0] mag;
        logic [63:0] aligned;
        logic [31:0] lo;
        int          width;
        int          lead;
        int          bias;
        width = op[1] ? 64 : 32;
        bias  = fmt ? 1023 : 127;
        sign  = 1'b0;
        lo    = data[31:0];
        mag   = op[1] ? data : {32'h0, lo};
        if (op == fp_cvt_pkg::op_i64 && data[63]) begin
            sign = 1'b1;
            mag  = ~data + 64'd1;
        end
        if (op == fp_cvt_pkg::op_i32 && lo[31]) begin
            sign = 1'b1;
            lo   = ~lo + 32'd1;
            mag  = {32'h0, lo};
        end
        // leading zeros within the operand width
        lead = width;
        for (int i = 0; i < width; i++) begin
            if (mag[i]) begin
                lead = width - 1 - i;
            end
        end
        zero    = (lead == width);
        aligned = mag << (64 - width + lead);
        expo    = 14'(width - 1 + bias - lead);
        if (fmt) begin
            mant = {1'b0, aligned[63:11]};
            grs  = {aligned[10], aligned[9], |aligned[8:0]};
        end else begin
            mant = {30'h0, aligned[63:40]};
            grs  = {aligned[39], aligned[38], |aligned[37:0]};
        end
        if (zero) begin
            expo = '0;
            mant = '0;
            grs  = '0;
        end
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hv <= '0;
        end else begin
            hv <= {hv[1:0], valid_i};
        end
    end

    always_ff @(posedge clk) begin
        hop   <= {hop[1:0], op_i};
        hfmt  <= {hfmt[1:0], fmt_i};
        hrm   <= {hrm[1:0], rm_i};
        hdata <= {hdata[1:0], data_i};
    end

    always_comb begin
        model(hop[2], hfmt[2], hdata[2], e_sign, e_exp, e_mant, e_grs, e_zero);
    end

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !valid_o && !sign_o && exponent_o == '0 && mantissa_o == '0
                   && grs_o == '0 && fmt_o == '0 && rm_o == '0 && !zero_o)
        else begin
            $error("outputs not cleared while in reset");
            fail_count++;
        end

    // one result per accepted operand three edges later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o == hv[2])
        else begin
            $error("valid_o %b does not follow valid_i from three cycles back", valid_o);
            fail_count++;
        end

    a_fields: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> sign_o == e_sign && exponent_o == e_exp && mantissa_o == e_mant
                    && grs_o == e_grs && zero_o == e_zero)
        else begin
            $error("result fields differ from the conversion rule, data %h", hdata[2]);
            fail_count++;
        end

    a_passthrough: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> fmt_o == hfmt[2] && rm_o == hrm[2])
        else begin
            $error("fmt_o or rm_o not carried through");
            fail_count++;
        end

    a_zero_clean: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o && zero_o |-> exponent_o == '0 && mantissa_o == '0 && grs_o == '0)
        else begin
            $error("zero result with nonzero exponent or mantissa");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb_fp_i2f_cvt.sv */
// integer to float converter testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fp_i2f_cvt;

    // about five times what the tests need
    localparam int max_cycles = 2000;

    logic        clk;
    logic        rst_n;
    logic        valid_i;
    logic [1:0]  op_i;
    logic        fmt_i;
    logic [2:0]  rm_i;
    logic [63:0] data_i;
    logic        valid_o;
    logic        sign_o;
    logic [13:0] exponent_o;
    logic [53:0] mantissa_o;
    logic [2:0]  grs_o;
    logic        fmt_o;
    logic [2:0]  rm_o;
    logic        zero_o;

    int          seed;
    int          cycles = 0;
    int          issued = 0;
    int          received = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int unsigned fails_before = 0;

    tb_clock_gen clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fp_i2f_cvt dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .fmt_i      (fmt_i),
        .rm_i       (rm_i),
        .data_i     (data_i),
        .valid_o    (valid_o),
        .sign_o     (sign_o),
        .exponent_o (exponent_o),
        .mantissa_o (mantissa_o),
        .grs_o      (grs_o),
        .fmt_o      (fmt_o),
        .rm_o       (rm_o),
        .zero_o     (zero_o)
    );

    bind fp_i2f_cvt fp_i2f_cvt_sva sva0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .fmt_i      (fmt_i),
        .rm_i       (rm_i),
        .data_i     (data_i),
        .valid_o    (valid_o),
        .sign_o     (sign_o),
        .exponent_o (exponent_o),
        .mantissa_o (mantissa_o),
        .grs_o      (grs_o),
        .fmt_o      (fmt_o),
        .rm_o       (rm_o),
        .zero_o     (zero_o)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && valid_o) begin
            received <= received + 1;
        end
        if (cycles >= max_cycles) begin
            $display("timeout: results still missing after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic issue(input logic [1:0] op, input logic fmt, input logic [2:0] rm,
                         input logic [63:0] data);
        @(posedge clk);
        valid_i <= 1'b1;
        op_i    <= op;
        fmt_i   <= fmt;
        rm_i    <= rm;
        data_i  <= data;
        issued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i <= 1'b0;
        end
    endtask

    // wait for every issued operand to come out and then check the failure count
    task automatic close_test(input string name);
        int unsigned delta;
        idle(1);
        while (received < issued) @(posedge clk);
        repeat (2) @(posedge clk);
        delta = dut0.sva0.fail_count - fails_before;
        fails_before = dut0.sva0.fail_count;
        tests_run++;
        if (delta != 0) begin
            tests_failed++;
            $display("ERROR %s: expected 0 assertion failures, actual %0d", name, delta);
        end else begin
            $display("%s: done", name);
        end
    endtask

    function automatic logic [63:0] random_operand();
        logic [63:0] v;
        int          sh;
        v  = {$random(seed), $random(seed)};
        sh = $unsigned($random(seed)) % 64;
        return $signed(v) >>> sh;
    endfunction

    initial begin
        seed    = 32'h36a6;
        valid_i = 1'b0;
        op_i    = 2'd0;
        fmt_i   = 1'b0;
        rm_i    = 3'd0;
        data_i  = 64'h0;
        while (!rst_n) @(posedge clk);

        idle(3);
        issue(fp_cvt_pkg::op_u32, fp_cvt_pkg::fmt_single, 3'd0, 64'h1);
        idle(5);
        issue(fp_cvt_pkg::op_i64, fp_cvt_pkg::fmt_double, 3'd1, 64'd12345);
        idle(4);
        close_test("reset_latency");

        // junk in the upper half must be ignored
        issue(fp_cvt_pkg::op_i32, fp_cvt_pkg::fmt_single, 3'd0, {32'hdeadbeef, 32'd5});
        issue(fp_cvt_pkg::op_i32, fp_cvt_pkg::fmt_single, 3'd1, {32'hdeadbeef, -32'sd5});
        issue(fp_cvt_pkg::op_i32, fp_cvt_pkg::fmt_single, 3'd2, {32'h0, 32'hffffffff});
        issue(fp_cvt_pkg::op_i32, fp_cvt_pkg::fmt_single, 3'd3, {32'h12345678, 32'h80000000});
        issue(fp_cvt_pkg::op_i32, fp_cvt_pkg::fmt_single, 3'd4, {32'h0, 32'h7fffffff});
        issue(fp_cvt_pkg::op_i32, fp_cvt_pkg::fmt_single, 3'd5, {32'hffffffff, 32'd16777217});
        close_test("signed32_to_single");

        issue(fp_cvt_pkg::op_u64, fp_cvt_pkg::fmt_double, 3'd0, 64'hffff_ffff_ffff_ffff);
        issue(fp_cvt_pkg::op_u64, fp_cvt_pkg::fmt_double, 3'd1, 64'h8000_0000_0000_0400);
        issue(fp_cvt_pkg::op_u64, fp_cvt_pkg::fmt_double, 3'd2, 64'h8000_0000_0000_0200);
        issue(fp_cvt_pkg::op_u64, fp_cvt_pkg::fmt_double, 3'd3, 64'h8000_0000_0000_0001);
        issue(fp_cvt_pkg::op_u64, fp_cvt_pkg::fmt_double, 3'd4, 64'h0123_4567_89ab_cdef);
        issue(fp_cvt_pkg::op_u64, fp_cvt_pkg::fmt_double, 3'd5, 64'h0000_0000_0000_0fff);
        close_test("unsigned64_to_double");

        for (int op = 0; op < 4; op++) begin
            for (int f = 0; f < 2; f++) begin
                issue(2'(op), 1'(f), 3'(op), (op > 1) ? 64'h0 : 64'hffff_0000_0000_0000);
            end
        end
        close_test("zero_operand");

        repeat (200) begin
            issue(2'($random(seed)), 1'($random(seed)), 3'($random(seed)), random_operand());
        end
        close_test("random_back_to_back");

        $display("tests run %0d, tests failed %0d, assertion failures %0d",
                 tests_run, tests_failed, dut0.sva0.fail_count);
        if (tests_failed == 0 && dut0.sva0.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fp_i2f_cvt.f */
fp_cvt_pkg.sv
i2f_stage_if.sv
i2f_operand_unpack.sv
lzc_64.sv
i2f_normalize.sv
i2f_result_pack.sv
fp_i2f_cvt.sv
tb_clock_gen.sv
fp_i2f_cvt_sva.sv
tb_fp_i2f_cvt.sv

/* run_sim.sh */
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fp_i2f_cvt -f fp_i2f_cvt.f
./obj_dir/Vtb_fp_i2f_cvt +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
